/* rtl/csrAddrPkg.sv */
/*
  CSR address map, privilege modes and access opcodes for the
  performance-counter unit. Referenced by scoped name from the
  access port, the control registers and the counter block.
*/

package csrAddrPkg;

  ////////////////////
  // counter csr windows
  ////////////////////
  localparam logic [11:0] mhpmCounterBase  = 12'hB00; // machine counters, low halves
  localparam logic [11:0] mhpmCounterHBase = 12'hB80; // machine counters, high halves
  localparam logic [11:0] hpmCounterBase   = 12'hC00; // user shadow, read only
  localparam logic [11:0] hpmCounterHBase  = 12'hC80; // user shadow of high halves

  // time sits inside the user shadow window at counter slot 1
  localparam logic [11:0] timeAdr  = 12'hC01;
  localparam logic [11:0] timeHAdr = 12'hC81;

  ////////////////////
  // counter control csrs
  ////////////////////
  localparam logic [11:0] mcountinhibitAdr = 12'h320;
  localparam logic [11:0] mcounterenAdr    = 12'h306;
  localparam logic [11:0] scounterenAdr    = 12'h106;

  localparam int xlen = 32; // csr data width, rv32 only

  // privilege encodings follow the privileged spec
  typedef enum logic [1:0] {
    userMode       = 2'b00,
    supervisorMode = 2'b01,
    machineMode    = 2'b11
  } privMode_t;

  typedef enum logic {
    csrRead  = 1'b0,
    csrWrite = 1'b1
  } csrOp_t;

endpackage

/* rtl/perfEventPkg.sv */
/*
  Counter count and fixed event wiring of the performance-counter
  unit. Each localparam is the counter slot its event lands in.
  Slot 1 has no event and stays unimplemented.
*/

package perfEventPkg;

  localparam int numCounters = 8; // counters 0..7, slot 1 unused

  ////////////////////
  // event to counter slot
  ////////////////////
  localparam logic [2:0] evCycle        = 3'd0; // mcycle
  localparam logic [2:0] evInstret      = 3'd2; // minstret
  localparam logic [2:0] evLoadStall    = 3'd3; // load-use stalls
  localparam logic [2:0] evBranchMiss   = 3'd4; // direction mispredicts
  localparam logic [2:0] evBranch       = 3'd5; // branches retired
  localparam logic [2:0] evDCacheAccess = 3'd6; // d$ accesses
  localparam logic [2:0] evDCacheMiss   = 3'd7; // d$ misses

endpackage

/* rtl/loadStallTracker.sv */
/*
  Carries the decode-stage load-stall flag down to the memory stage
  so the stall counter sees it alongside the other M-stage events.
  Two cycles of latency, each stage frozen by its own stall.
*/
`timescale 1ns/1ps

module loadStallTracker (
  input  logic clk,
  input  logic reset,
  input  logic stallE,
  input  logic stallM,
  input  logic flushM,
  input  logic loadStallD,
  output logic loadStallM
);

  logic loadStallE;

  // E stage has no flush: a stall that triggers a flush still counts
  always_ff @(posedge clk) begin
    if (reset) loadStallE <= 1'b0;
    else if (!stallE) loadStallE <= loadStallD;
  end

  always_ff @(posedge clk) begin
    if (reset) loadStallM <= 1'b0;
    else if (flushM) loadStallM <= 1'b0;      // flush wins over stall
    else if (!stallM) loadStallM <= loadStallE;
  end

endmodule

/* rtl/counterControlRegs.sv */
/*
  mcountinhibit, mcounteren and scounteren. Decodes its own three
  addresses off the broadcast access bus and answers with a read
  value, a hit and an illegal flag. Machine mode only.
*/
`timescale 1ns/1ps

module counterControlRegs (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   writeStrobe,
  input  logic [11:0]                            accessAdr,
  input  csrAddrPkg::privMode_t                  accessPriv,
  input  logic [csrAddrPkg::xlen-1:0]            writeData,
  output logic [csrAddrPkg::xlen-1:0]            ctrlReadVal,
  output logic                                   ctrlHit,
  output logic                                   ctrlIllegal,
  output logic [perfEventPkg::numCounters-1:0]   inhibit,
  output logic [perfEventPkg::numCounters-1:0]   counterEn,
  output logic [perfEventPkg::numCounters-1:0]   sCounterEn
);

  logic selInhibit, selCounterEn, selSCounterEn;
  logic [perfEventPkg::numCounters-1:0] readBits;

  assign selInhibit    = (accessAdr == csrAddrPkg::mcountinhibitAdr);
  assign selCounterEn  = (accessAdr == csrAddrPkg::mcounterenAdr);
  assign selSCounterEn = (accessAdr == csrAddrPkg::scounterenAdr);

  assign ctrlHit     = selInhibit | selCounterEn | selSCounterEn;
  assign ctrlIllegal = ctrlHit & (accessPriv != csrAddrPkg::machineMode);

  ////////////////////
  // registers
  ////////////////////
  // strobe only fires on a legal access, so priv is already checked
  always_ff @(posedge clk) begin
    if (reset) begin
      inhibit    <= '0;                       // everything counts
      counterEn  <= '0;                       // lower modes locked out
      sCounterEn <= '0;
    end else if (writeStrobe) begin
      if (selInhibit)    inhibit    <= writeData[perfEventPkg::numCounters-1:0];
      if (selCounterEn)  counterEn  <= writeData[perfEventPkg::numCounters-1:0];
      if (selSCounterEn) sCounterEn <= writeData[perfEventPkg::numCounters-1:0];
    end
  end

  // read back, upper bits read as zero
  always_comb begin
    readBits = '0;
    if (selInhibit)         readBits = inhibit;
    else if (selCounterEn)  readBits = counterEn;
    else if (selSCounterEn) readBits = sCounterEn;
  end

  assign ctrlReadVal = ctrlIllegal ? '0 :
    {{(csrAddrPkg::xlen - perfEventPkg::numCounters){1'b0}}, readBits};

endmodule

/* rtl/hpmCounters.sv */
/*
  Hardware performance counters. Eight 64-bit counters seen as low
  and high 32-bit CSRs, plus time/timeh shadowing the external mtime.
  Gates the fixed events, counts, handles half writes, and decodes
  reads and privilege for its own address windows.
*/
`timescale 1ns/1ps

module hpmCounters (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 writeStrobe,
  input  logic                                 instrValid,
  input  logic                                 branchMiss,
  input  logic                                 branch,
  input  logic                                 dCacheAccess,
  input  logic                                 dCacheMiss,
  input  logic                                 loadStallM,
  input  logic [11:0]                          accessAdr,
  input  csrAddrPkg::privMode_t                accessPriv,
  input  logic                                 accessIsWrite,
  input  logic [csrAddrPkg::xlen-1:0]          writeData,
  input  logic [perfEventPkg::numCounters-1:0] inhibit,
  input  logic [perfEventPkg::numCounters-1:0] counterEn,
  input  logic [perfEventPkg::numCounters-1:0] sCounterEn,
  input  logic [63:0]                          mtime,
  output logic [csrAddrPkg::xlen-1:0]          cntReadVal,
  output logic                                 cntHit,
  output logic                                 cntIllegal
);

  logic [perfEventPkg::numCounters-1:0] events;      // raw event per slot
  logic [perfEventPkg::numCounters-1:0] implemented; // slots with a source
  logic [perfEventPkg::numCounters-1:0] countInc;
  logic [perfEventPkg::numCounters-1:0][csrAddrPkg::xlen-1:0] countLo;
  logic [perfEventPkg::numCounters-1:0][csrAddrPkg::xlen-1:0] countHi;
  logic [$clog2(perfEventPkg::numCounters)-1:0] cntIdx;
  logic inMLo, inMHi, inULo, inUHi;
  logic isTime, isTimeH;
  logic privOk, badWrite, missing;
  logic [csrAddrPkg::xlen-1:0] rawRead;

  ////////////////////
  // event wiring
  ////////////////////
  always_comb begin
    events      = '0;                 // slot 1 stays quiet
    implemented = '0;
    events[perfEventPkg::evCycle]        = 1'b1;              // every clock
    events[perfEventPkg::evInstret]      = instrValid;
    events[perfEventPkg::evLoadStall]    = loadStallM;        // already M-stage aligned
    events[perfEventPkg::evBranchMiss]   = branchMiss & instrValid;
    events[perfEventPkg::evBranch]       = branch & instrValid;
    events[perfEventPkg::evDCacheAccess] = dCacheAccess;
    events[perfEventPkg::evDCacheMiss]   = dCacheMiss;
    implemented[perfEventPkg::evCycle]        = 1'b1;
    implemented[perfEventPkg::evInstret]      = 1'b1;
    implemented[perfEventPkg::evLoadStall]    = 1'b1;
    implemented[perfEventPkg::evBranchMiss]   = 1'b1;
    implemented[perfEventPkg::evBranch]       = 1'b1;
    implemented[perfEventPkg::evDCacheAccess] = 1'b1;
    implemented[perfEventPkg::evDCacheMiss]   = 1'b1;
  end

  assign countInc = events & ~inhibit;

  ////////////////////
  // counters
  ////////////////////
  for (genvar i = 0; i < perfEventPkg::numCounters; i++) begin : gCounter
    logic [63:0] countPlus;
    logic writeLo, writeHi;

    assign countPlus = {countHi[i], countLo[i]} + 64'(countInc[i]);
    assign writeLo = writeStrobe & (accessAdr == csrAddrPkg::mhpmCounterBase + 12'(i));
    assign writeHi = writeStrobe & (accessAdr == csrAddrPkg::mhpmCounterHBase + 12'(i));

    // a write replaces one half and drops this cycle's increment
    always_ff @(posedge clk) begin
      if (reset) begin
        countLo[i] <= '0;
        countHi[i] <= '0;
      end else if (writeLo) begin
        countLo[i] <= writeData;
      end else if (writeHi) begin
        countHi[i] <= writeData;
      end else begin
        countLo[i] <= countPlus[31:0];
        countHi[i] <= countPlus[63:32];
      end
    end
  end

  ////////////////////
  // read decode
  ////////////////////
  // windows are aligned, low address bits pick the counter
  assign cntIdx = accessAdr[$clog2(perfEventPkg::numCounters)-1:0];
  assign inMLo = (accessAdr >= csrAddrPkg::mhpmCounterBase) &&
                 (accessAdr <  csrAddrPkg::mhpmCounterBase + 12'(perfEventPkg::numCounters));
  assign inMHi = (accessAdr >= csrAddrPkg::mhpmCounterHBase) &&
                 (accessAdr <  csrAddrPkg::mhpmCounterHBase + 12'(perfEventPkg::numCounters));
  assign inULo = (accessAdr >= csrAddrPkg::hpmCounterBase) &&
                 (accessAdr <  csrAddrPkg::hpmCounterBase + 12'(perfEventPkg::numCounters));
  assign inUHi = (accessAdr >= csrAddrPkg::hpmCounterHBase) &&
                 (accessAdr <  csrAddrPkg::hpmCounterHBase + 12'(perfEventPkg::numCounters));
  assign isTime  = (accessAdr == csrAddrPkg::timeAdr);
  assign isTimeH = (accessAdr == csrAddrPkg::timeHAdr);

  assign cntHit = inMLo | inMHi | inULo | inUHi; // time falls inside the user windows

  // S needs mcounteren, U needs mcounteren and scounteren
  always_comb begin
    case (accessPriv)
      csrAddrPkg::machineMode:    privOk = 1'b1;
      csrAddrPkg::supervisorMode: privOk = counterEn[cntIdx];
      default:                    privOk = counterEn[cntIdx] & sCounterEn[cntIdx];
    endcase
  end

  assign badWrite = accessIsWrite &
                    (inULo | inUHi | (accessPriv != csrAddrPkg::machineMode));
  assign missing  = (inMLo | inMHi) & ~implemented[cntIdx];  // slot 1 in machine window
  assign cntIllegal = cntHit & (~privOk | badWrite | missing);

  always_comb begin
    rawRead = '0;
    if (isTime)              rawRead = mtime[31:0];
    else if (isTimeH)        rawRead = mtime[63:32];
    else if (inMLo | inULo)  rawRead = countLo[cntIdx];
    else if (inMHi | inUHi)  rawRead = countHi[cntIdx];
  end

  assign cntReadVal = cntIllegal ? '0 : rawRead;

endmodule

/* rtl/csrAccessPort.sv */
/*
  Four-phase req/ack front end for the counter CSRs. Latches one
  request, broadcasts it to the control and counter blocks for a
  single exec cycle, merges their answers and returns rdata and
  illegal with ack. ack holds until req is seen low.
*/
`timescale 1ns/1ps

module csrAccessPort (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req,
  input  logic [11:0]                   adr,
  input  csrAddrPkg::csrOp_t            op,
  input  logic [csrAddrPkg::xlen-1:0]   wdata,
  input  csrAddrPkg::privMode_t         priv,
  input  logic [csrAddrPkg::xlen-1:0]   ctrlReadVal,
  input  logic [csrAddrPkg::xlen-1:0]   cntReadVal,
  input  logic                          ctrlHit,
  input  logic                          ctrlIllegal,
  input  logic                          cntHit,
  input  logic                          cntIllegal,
  output logic                          ack,
  output logic [csrAddrPkg::xlen-1:0]   rdata,
  output logic                          illegal,
  output logic [11:0]                   accessAdr,
  output csrAddrPkg::privMode_t         accessPriv,
  output logic                          accessIsWrite,
  output logic                          writeStrobe,
  output logic [csrAddrPkg::xlen-1:0]   writeData
);

  typedef enum logic [1:0] {stIdle, stExec, stDone} portState_t;

  portState_t                  state;
  logic                        mergedIllegal;
  logic [csrAddrPkg::xlen-1:0] mergedVal;

  // idle -> exec on req, exec lasts one cycle, done waits for req low
  always_ff @(posedge clk) begin
    if (reset) state <= stIdle;
    else begin
      case (state)
        stIdle:  if (req) state <= stExec;
        stExec:  state <= stDone;
        stDone:  if (!req) state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  // request latch, held stable through exec
  always_ff @(posedge clk) begin
    if (state == stIdle && req) begin
      accessAdr     <= adr;
      accessPriv    <= priv;
      accessIsWrite <= (op == csrAddrPkg::csrWrite);
      writeData     <= wdata;
    end
  end

  ////////////////////
  // result merge
  ////////////////////
  always_comb begin
    if (ctrlHit) begin
      mergedVal     = ctrlReadVal;
      mergedIllegal = ctrlIllegal;
    end else if (cntHit) begin
      mergedVal     = cntReadVal;
      mergedIllegal = cntIllegal;
    end else begin
      mergedVal     = '0;           // nobody claims the address
      mergedIllegal = 1'b1;
    end
  end

  // exec sees the pre-write value, the write lands at the end of exec
  assign writeStrobe = (state == stExec) & accessIsWrite & ~mergedIllegal;
  assign ack         = (state == stDone);

  always_ff @(posedge clk) begin
    if (reset) illegal <= 1'b0;
    else if (state == stExec) illegal <= mergedIllegal;
  end

  always_ff @(posedge clk) begin
    if (state == stExec) rdata <= mergedVal;
  end

endmodule

/* rtl/counterCsrTop.sv */
/*
  Performance-counter unit top. Ties the req/ack access port to
  the control registers and the counters, and feeds the load-stall
  flag through its pipeline tracker.
*/
`timescale 1ns/1ps

module counterCsrTop (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req,
  input  logic [11:0]                   adr,
  input  csrAddrPkg::csrOp_t            op,
  input  logic [csrAddrPkg::xlen-1:0]   wdata,
  input  csrAddrPkg::privMode_t         priv,
  output logic                          ack,
  output logic [csrAddrPkg::xlen-1:0]   rdata,
  output logic                          illegal,
  input  logic                          stallE,
  input  logic                          stallM,
  input  logic                          flushM,
  input  logic                          loadStallD,
  input  logic                          instrValid,
  input  logic                          branchMiss,
  input  logic                          branch,
  input  logic                          dCacheAccess,
  input  logic                          dCacheMiss,
  input  logic [63:0]                   mtime
);

  // broadcast access bus
  logic [11:0]                 accessAdr;
  csrAddrPkg::privMode_t       accessPriv;
  logic                        accessIsWrite, writeStrobe;
  logic [csrAddrPkg::xlen-1:0] writeData;

  // block answers
  logic [csrAddrPkg::xlen-1:0] ctrlReadVal, cntReadVal;
  logic                        ctrlHit, ctrlIllegal, cntHit, cntIllegal;

  logic [perfEventPkg::numCounters-1:0] inhibit, counterEn, sCounterEn;
  logic                                 loadStallM;

  csrAccessPort port (.*);

  counterControlRegs ctrlRegs (.*);

  loadStallTracker stallTrack (.*);

  hpmCounters counters (.*);

endmodule

/* tb/counterCsr_props.sv */
/*
  Handshake and reset assertions for the CSR access port.
  Bound into every csrAccessPort instance. The testbench reads
  assertFails at the end of the run and folds it into its summary.
*/
`timescale 1ns/1ps

module counterCsr_props (
  input logic clk,
  input logic reset,
  input logic req,
  input logic ack,
  input logic writeStrobe
);

  int assertFails = 0; // failed assertion attempts so far

  // ack answers a request that was still up one edge earlier
  ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req))
    else begin
      assertFails++;
      $error("ack rose with no request pending");
    end

  strobeOneCycle: assert property (@(posedge clk) disable iff (reset)
    writeStrobe |=> !writeStrobe)
    else begin
      assertFails++;
      $error("writeStrobe held for more than one cycle");
    end

  // reset leaves the port idle with nothing acked or written
  quietAfterReset: assert property (@(posedge clk)
    reset |=> !ack && !writeStrobe)
    else begin
      assertFails++;
      $error("ack or writeStrobe high right after reset");
    end

endmodule

bind csrAccessPort counterCsr_props props (.*);

/* tb/counterCsrTb.sv */
/*
  Testbench for the performance-counter CSR unit. Runs a table of
  four-phase CSR accesses, some preceded by random event traffic,
  and checks rdata and illegal against values from the CSR rules.
  Ends with an mcycle delta check and one summary line.
*/
`timescale 1ns/1ps

module counterCsrTb;

  localparam csrAddrPkg::csrOp_t    opRd = csrAddrPkg::csrRead;
  localparam csrAddrPkg::csrOp_t    opWr = csrAddrPkg::csrWrite;
  localparam csrAddrPkg::privMode_t pU   = csrAddrPkg::userMode;
  localparam csrAddrPkg::privMode_t pS   = csrAddrPkg::supervisorMode;
  localparam csrAddrPkg::privMode_t pM   = csrAddrPkg::machineMode;

  typedef struct packed {
    logic [8*12-1:0]       name;
    csrAddrPkg::csrOp_t    op;
    csrAddrPkg::privMode_t priv;
    logic [11:0]           adr;
    logic [31:0]           wdata;
    logic [2:0]            evSel;    // counter slot whose event is driven
    logic [7:0]            evCount;  // random event cycles before the access
    logic [31:0]           expRdata; // base value before event hits
    logic                  expIllegal;
  } entry_t;

  logic clk, reset, req, ack, illegal;
  logic [11:0] adr;
  csrAddrPkg::csrOp_t op;
  csrAddrPkg::privMode_t priv;
  logic [31:0] wdata, rdata;
  logic stallE, stallM, flushM, loadStallD, instrValid;
  logic branchMiss, branch, dCacheAccess, dCacheMiss;
  logic [63:0] mtime;

  entry_t stim[$];
  int seed = 76;
  int errors = 0;
  int checks = 0;
  int cycles = 0;       // rising edges since time zero
  int limitCycles = 0;  // watchdog budget in cycles

  counterCsrTop dut (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;
  always @(posedge clk) cycles <= cycles + 1;

  ////////////////////
  // helpers
  ////////////////////
  task automatic doAccess(input csrAddrPkg::csrOp_t o, input csrAddrPkg::privMode_t p,
                          input logic [11:0] a, input logic [31:0] wd,
                          output logic [31:0] rdOut, output logic ill, output int reqCycle);
    @(negedge clk);
    req = 1'b1;
    op = o;
    priv = p;
    adr = a;
    wdata = wd;
    reqCycle = cycles;              // next rising edge samples req
    while (!ack) @(negedge clk);
    rdOut = rdata;
    ill = illegal;
    req = 1'b0;
    while (ack) @(negedge clk);     // wait for ack to drop
  endtask

  task automatic checkValue(input logic [8*12-1:0] nm, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %0s %0s: expected %h, actual %h", nm, what, exp, act);
    end
  endtask

  // random traffic on one event followed by 3 quiet cycles that drain the tracker
  task automatic runEvents(input logic [2:0] sel, input int n, output int hits);
    logic [31:0] r;
    logic pe, pm;                   // model of the tracker's E and M stages
    hits = 0;
    pe = 1'b0;
    pm = 1'b0;
    for (int k = 0; k < n + 3; k++) begin
      @(negedge clk);
      r = (k < n) ? $random(seed) : 32'h0;
      instrValid = r[0];
      branch     = (sel == 3'd5) & r[1];
      loadStallD = (sel == 3'd3) & r[2];
      flushM     = (sel == 3'd3) & r[3] & r[4];
      stallE     = (sel == 3'd3) & r[5] & r[6];
      stallM     = (sel == 3'd3) & r[7] & r[8];
      if (sel == 3'd5) hits += branch & instrValid;  // only retired branches
      if (sel == 3'd3) begin
        hits += pm;                                  // M stage counted at the edge
        pm = flushM ? 1'b0 : (stallM ? pm : pe);
        pe = stallE ? pe : loadStallD;
      end
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    logic [31:0] got, first;
    logic gotIll;
    int c1, c2, hits, budget, assertFails;
    {req, stallE, stallM, flushM, loadStallD, instrValid} = '0;
    {branchMiss, branch, dCacheAccess, dCacheMiss} = '0;
    adr = '0;
    op = opRd;
    priv = pM;
    wdata = '0;
    mtime = 64'h0123_4567_89AB_CDEF;
    reset = 1'b1;

    stim.push_back('{"rstInhibit", opRd, pM, 12'h320, 32'h0, 3'd0, 0, 32'h0, 1'b0});
    stim.push_back('{"inhibitAll", opWr, pM, 12'h320, 32'hFF, 3'd0, 0, 32'h0, 1'b0});
    stim.push_back('{"zeroCnt5", opWr, pM, 12'hB05, 32'h0, 3'd0, 0, 32'h0, 1'b0});
    stim.push_back('{"zeroCnt3", opWr, pM, 12'hB03, 32'h0, 3'd0, 0, 32'h0, 1'b0});
    stim.push_back('{"wrLo6", opWr, pM, 12'hB06, 32'h1234_5678, 3'd0, 0, 32'h0, 1'b0});
    stim.push_back('{"wrHi6", opWr, pM, 12'hB86, 32'hCAFE_0001, 3'd0, 0, 32'h0, 1'b0});
    stim.push_back('{"rdLo6", opRd, pM, 12'hB06, 32'h0, 3'd0, 0, 32'h1234_5678, 1'b0});
    stim.push_back('{"rdHi6", opRd, pM, 12'hB86, 32'h0, 3'd0, 0, 32'hCAFE_0001, 1'b0});
    stim.push_back('{"sRdNoEn", opRd, pS, 12'hC06, 32'h0, 3'd0, 0, 32'h0, 1'b1});
    stim.push_back('{"setMcen", opWr, pM, 12'h306, 32'h40, 3'd0, 0, 32'h0, 1'b0});
    stim.push_back('{"sRdEn", opRd, pS, 12'hC06, 32'h0, 3'd0, 0, 32'h1234_5678, 1'b0});
    stim.push_back('{"uRdNoSen", opRd, pU, 12'hC06, 32'h0, 3'd0, 0, 32'h0, 1'b1});
    stim.push_back('{"setScen", opWr, pM, 12'h106, 32'h40, 3'd0, 0, 32'h0, 1'b0});
    stim.push_back('{"uRdEn", opRd, pU, 12'hC86, 32'h0, 3'd0, 0, 32'hCAFE_0001, 1'b0});
    stim.push_back('{"uWrShadow", opWr, pU, 12'hC06, 32'h5, 3'd0, 0, 32'h0, 1'b1});
    stim.push_back('{"sWrMach", opWr, pS, 12'hB06, 32'h5, 3'd0, 0, 32'h0, 1'b1});
    stim.push_back('{"mWrShadow", opWr, pM, 12'hC06, 32'h5, 3'd0, 0, 32'h0, 1'b1});
    stim.push_back('{"mWrTime", opWr, pM, 12'hC01, 32'h5, 3'd0, 0, 32'h0, 1'b1});
    stim.push_back('{"rdCnt1", opRd, pM, 12'hB01, 32'h0, 3'd0, 0, 32'h0, 1'b1});
    stim.push_back('{"wrCnt1", opWr, pM, 12'hB01, 32'h5, 3'd0, 0, 32'h0, 1'b1});
    stim.push_back('{"sCtrlRd", opRd, pS, 12'h320, 32'h0, 3'd0, 0, 32'h0, 1'b1});
    stim.push_back('{"noSuchCsr", opRd, pM, 12'h123, 32'h0, 3'd0, 0, 32'h0, 1'b1});
    stim.push_back('{"timeLo", opRd, pM, 12'hC01, 32'h0, 3'd0, 0, 32'h89AB_CDEF, 1'b0});
    stim.push_back('{"timeHi", opRd, pM, 12'hC81, 32'h0, 3'd0, 0, 32'h0123_4567, 1'b0});
    stim.push_back('{"enBranch", opWr, pM, 12'h320, 32'hDF, 3'd0, 0, 32'hFF, 1'b0});
    stim.push_back('{"branchCnt", opRd, pM, 12'hB05, 32'h0, 3'd5, 60, 32'h0, 1'b0});
    stim.push_back('{"enLoadStall", opWr, pM, 12'h320, 32'hF7, 3'd0, 0, 32'hDF, 1'b0});
    stim.push_back('{"stallCnt", opRd, pM, 12'hB03, 32'h0, 3'd3, 60, 32'h0, 1'b0});
    stim.push_back('{"clrInhibit", opWr, pM, 12'h320, 32'h0, 3'd0, 0, 32'hF7, 1'b0});

    budget = 100;                   // reset plus the mcycle reads
    foreach (stim[i]) budget += 20 + stim[i].evCount + 3;
    limitCycles = budget;

    repeat (10) @(negedge clk);
    reset = 1'b0;

    foreach (stim[i]) begin
      hits = 0;
      if (stim[i].evCount != 0) runEvents(stim[i].evSel, stim[i].evCount, hits);
      doAccess(stim[i].op, stim[i].priv, stim[i].adr, stim[i].wdata, got, gotIll, c1);
      checkValue(stim[i].name, "rdata", stim[i].expRdata + hits, got);
      checkValue(stim[i].name, "illegal", {31'b0, stim[i].expIllegal}, {31'b0, gotIll});
    end

    // mcycle advances once per clock and read latency is fixed
    doAccess(opRd, pM, 12'hB00, 32'h0, first, gotIll, c1);
    repeat (13) @(negedge clk);
    doAccess(opRd, pM, 12'hB00, 32'h0, got, gotIll, c2);
    checkValue("mcycleDelta", "rdata", c2 - c1, got - first);

    assertFails = dut.port.props.assertFails;
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors, assertFails);
    if (errors == 0 && assertFails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog ends a run whose handshake got stuck
  initial begin
    wait (limitCycles != 0);
    repeat (limitCycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limitCycles);
    $display("Something failed");
    $finish;
  end

endmodule

/* all.f */
rtl/csrAddrPkg.sv
rtl/perfEventPkg.sv
rtl/loadStallTracker.sv
rtl/counterControlRegs.sv
rtl/hpmCounters.sv
rtl/csrAccessPort.sv
rtl/counterCsrTop.sv
tb/counterCsr_props.sv
tb/counterCsrTb.sv
